//--- Bender.yml
package:
  name: lz_tile

sources:
  - logic/lz_tile_pkg.sv
  - logic/lz_tile_ifs.sv
  - logic/lz_history_tile.sv
  - logic/lz_longest_tree.sv
  - logic/lz_mtf_lookup.sv
  - logic/lz_match_select.sv
  - logic/lz_tile_top.sv
  - target: test
    files:
      - dv/lz_tile_props.sv
      - dv/lz_tile_tb.sv

//--- dv/lz_tile_props.sv
// Concurrent checks on credit accounting and token timing of the tile.
// Bound into the tile top level, with the credit counter taken from
// the history stage.
`timescale 1ns/1ps
`default_nettype none

module lz_tile_props #(
   parameter int CREDITS = 4
) (
   input wire logic                         clk,
   input wire logic                         rst_n,
   input wire logic                         in_valid,
   input wire logic                         in_ready,
   input wire logic                         tok_credit,
   input wire logic                         tok_valid,
   input wire logic [$clog2(CREDITS+1)-1:0] credit_cnt
);

   a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
      credit_cnt <= CREDITS)
      else $error("credit count above its initial value");

   // with no credit left and none coming back the intake stays closed
   a_ready_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (credit_cnt == '0 && !tok_credit) |=> !in_ready)
      else $error("in_ready rose with no credit returned");

   // a word taken at edge n shows up as a token sampled at edge n+3
   a_tok_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
      (in_valid && in_ready) |-> ##3 tok_valid)
      else $error("no token three edges after an accepted word");

   a_tok_has_accept: assert property (@(posedge clk) disable iff (!rst_n)
      tok_valid |-> $past(in_valid && in_ready, 3))
      else $error("token without an accepted word three edges before");

endmodule

bind lz_tile_top lz_tile_props #(.CREDITS(CREDITS)) u_props (
   .clk, .rst_n, .in_valid, .in_ready, .tok_credit, .tok_valid,
   .credit_cnt(u_history.credit_cnt)
);

`default_nettype wire

//--- dv/lz_tile_tb.sv
// Testbench for the LZ77 match-reduction tile.
// Drives random words under credit flow control, returns credits after a
// random delay, and checks every token against a reference model of the
// history compare, the longest-match choice and the MTF list.
`timescale 1ns/1ps
`default_nettype none

module lz_tile_tb import lz_tile_pkg::*; ();

   localparam int TILE_DEPTH   = 16;
   localparam int MTF_NUM      = 2;
   localparam int CREDITS      = 4;
   localparam int NUM_WORDS    = 2000;
   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int WATCHDOG_NS  = NUM_WORDS * CLK_PERIOD * 8 + RESET_CYCLES * CLK_PERIOD;

   logic                          clk = 1'b0;
   logic                          rst_n;
   logic                          in_valid;
   word_t                         in_data;
   logic                          tok_credit;
   logic                          in_ready;
   logic                          tok_valid;
   tok_kind_e                     tok_kind;
   logic [$clog2(TILE_DEPTH)-1:0] tok_offset;
   len_t                          tok_len;
   logic [$clog2(MTF_NUM)-1:0]    tok_mtf_idx;
   word_t                         tok_data;

   // model state, all in acceptance order
   byte_t stream[$];
   word_t acc_word[$];
   int    acc_edge[$];
   word_t sent_words[$];
   int    pend_edge[$];
   bit    pend_new[$];
   int    pend_val[$];
   int    mtf_off[MTF_NUM];
   bit    mtf_vld[MTF_NUM];
   int    credit_due[$];
   int    edge_cnt;
   int    model_credits;
   int    tok_seen;
   int    tok_handled;
   int    words_sent;
   bit    will_accept;

   lz_tile_top u_dut (
      .clk, .rst_n, .in_valid, .in_data, .tok_credit, .in_ready,
      .tok_valid, .tok_kind, .tok_offset, .tok_len, .tok_mtf_idx, .tok_data
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ======================================================================
   // reference model
   // ======================================================================
   task automatic compare_val(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s mismatch, got %0h, expected %0h",
                  $time, what, got, exp);
         $display("Verification failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // leading matching bytes of w at offset off, i.e. off + IN_BYTES bytes back
   function automatic int match_len(word_t w, int off);
      int q;
      int n;
      n = 0;
      for (int i = 0; i < IN_BYTES; i++) begin
         q = stream.size() + i - off - IN_BYTES;
         if (q < 0) break;
         if (stream[q] != w[i]) break;
         n++;
      end
      return n;
   endfunction

   task automatic apply_mtf(input bit is_new, input int val);
      int t_off;
      bit t_vld;
      t_off = is_new ? val : mtf_off[val];
      t_vld = is_new ? 1'b1 : mtf_vld[val];
      for (int k = (is_new ? MTF_NUM - 1 : val); k > 0; k--) begin
         mtf_off[k] = mtf_off[k-1];
         mtf_vld[k] = mtf_vld[k-1];
      end
      mtf_off[0] = t_off;
      mtf_vld[0] = t_vld;
   endtask

   task automatic check_token();
      word_t     w;
      int        e;
      int        l;
      int        best_len;
      int        best_off;
      int        rep_len;
      int        rep_idx;
      int        exp_off;
      int        exp_len;
      int        exp_idx;
      tok_kind_e kind;
      compare_val(acc_word.size() != 0, 1, "token with no outstanding word");
      w = acc_word.pop_front();
      e = acc_edge.pop_front();
      // a word only sees list updates of words taken two or more edges earlier
      while (pend_edge.size() != 0 && pend_edge[0] + 2 <= e) begin
         apply_mtf(pend_new.pop_front(), pend_val.pop_front());
         void'(pend_edge.pop_front());
      end
      best_len = 0;
      best_off = 0;
      for (int o = 0; o < TILE_DEPTH; o++) begin
         l = match_len(w, o);
         if (l > best_len) begin
            best_len = l;
            best_off = o;
         end
      end
      rep_len = 0;
      rep_idx = 0;
      for (int k = 0; k < MTF_NUM; k++) begin
         l = mtf_vld[k] ? match_len(w, mtf_off[k]) : 0;
         if (l > rep_len) begin
            rep_len = l;
            rep_idx = k;
         end
      end
      kind    = TOK_LIT;
      exp_off = 0;
      exp_len = 0;
      exp_idx = 0;
      if (rep_len >= MIN_MATCH && rep_len >= best_len) begin
         kind    = TOK_REP;
         exp_off = mtf_off[rep_idx];
         exp_len = rep_len;
         exp_idx = rep_idx;
         pend_edge.push_back(e);
         pend_new.push_back(1'b0);
         pend_val.push_back(rep_idx);
      end else if (best_len >= MIN_MATCH) begin
         kind    = TOK_MATCH;
         exp_off = best_off;
         exp_len = best_len;
         pend_edge.push_back(e);
         pend_new.push_back(1'b1);
         pend_val.push_back(best_off);
      end
      for (int i = 0; i < IN_BYTES; i++) stream.push_back(w[i]);
      // registered on the second edge after acceptance, seen at the third
      compare_val(edge_cnt - e, 2, "token latency");
      compare_val(tok_kind, kind, "token kind");
      compare_val(tok_offset, exp_off, "token offset");
      compare_val(tok_len, exp_len, "token length");
      compare_val(tok_mtf_idx, exp_idx, "token MTF index");
      compare_val(tok_data, w, "token data");
   endtask

   function automatic word_t random_word();
      word_t w;
      int    depth;
      // about a third of the words repeat a recent word
      if (sent_words.size() != 0 && $urandom_range(2, 0) == 0) begin
         depth = (sent_words.size() > 6) ? 6 : sent_words.size();
         w = sent_words[sent_words.size() - 1 - $urandom_range(depth - 1, 0)];
      end else begin
         for (int i = 0; i < IN_BYTES; i++) w[i] = byte_t'(8'h61 + $urandom_range(3, 0));
      end
      return w;
   endfunction

   // ======================================================================
   // output monitor, sampled away from the rising edge
   // ======================================================================
   always @(negedge clk) begin
      if (rst_n) begin
         if (tok_valid) begin
            check_token();
            tok_seen++;
         end
         compare_val(in_ready, model_credits != 0, "in_ready against credit count");
         will_accept = in_valid && in_ready;
         if (will_accept) begin
            acc_word.push_back(in_data);
            acc_edge.push_back(edge_cnt + 1);
         end
         model_credits += int'(tok_credit) - int'(will_accept);
      end
   end

   // ======================================================================
   // stimulus and credit return
   // ======================================================================
   initial begin
      word_t w;
      void'($urandom(32'hd3d4_ffdf));
      rst_n         = 1'b0;
      in_valid      = 1'b0;
      in_data       = '0;
      tok_credit    = 1'b0;
      edge_cnt      = 0;
      model_credits = CREDITS;
      tok_seen      = 0;
      tok_handled   = 0;
      words_sent    = 0;
      will_accept   = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      while (!(words_sent == NUM_WORDS && tok_handled == NUM_WORDS &&
               credit_due.size() == 0)) begin
         @(posedge clk);
         edge_cnt++;
         if (!in_valid || will_accept) begin
            if (words_sent < NUM_WORDS && $urandom_range(99, 0) < 70) begin
               w = random_word();
               sent_words.push_back(w);
               words_sent++;
               in_valid <= 1'b1;
               in_data  <= w;
            end else begin
               in_valid <= 1'b0;
            end
         end
         while (tok_handled < tok_seen) begin
            credit_due.push_back(edge_cnt + $urandom_range(6, 0));
            tok_handled++;
         end
         if (credit_due.size() != 0 && credit_due[0] <= edge_cnt) begin
            tok_credit <= 1'b1;
            void'(credit_due.pop_front());
         end else begin
            tok_credit <= 1'b0;
         end
      end
      @(posedge clk);
      tok_credit <= 1'b0;
      in_valid   <= 1'b0;
      repeat (3) @(posedge clk);
      if (tok_seen == NUM_WORDS && model_credits == CREDITS && in_ready) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("run ended with %0d tokens and %0d credits", tok_seen, model_credits);
         $display("Verification failed");
         $fatal(1, "end of run check failed");
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the run hung with tokens still missing");
      $display("Verification failed");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

//--- logic/lz_history_tile.sv
// Intake stage of the match tile.
// Holds the token credit counter, the sliding byte history with valid
// bits, and compares each accepted word at every candidate distance.
// Offset o looks o + IN_BYTES bytes back from each byte of the word.
`timescale 1ns/1ps
`default_nettype none

module lz_history_tile import lz_tile_pkg::*; #(
   parameter int TILE_DEPTH = 16,
   parameter int CREDITS    = 4
) (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire logic                         in_valid,
   input  wire word_t                        in_data,
   input  wire logic                         tok_credit,
   output logic                              in_ready,
   output logic                              cmp_valid,
   output len_therm_t [TILE_DEPTH-1:0]       cmp_therm,
   output word_t                             cmp_data
);

   localparam int HIST_LEN = TILE_DEPTH + IN_BYTES - 1;
   localparam int CW       = $clog2(CREDITS + 1);

   logic [CW-1:0]                        credit_cnt;
   logic                                 accept;
   byte_t [HIST_LEN-1:0]                 hist;
   logic [HIST_LEN-1:0]                  hist_vld;
   logic [TILE_DEPTH-1:0][IN_BYTES-1:0]  eq;
   len_therm_t [TILE_DEPTH-1:0]          therm;

   assign in_ready = (credit_cnt != '0);
   assign accept   = in_valid && in_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credit_cnt <= CW'(CREDITS);
         hist_vld   <= '0;
         cmp_valid  <= 1'b0;
      end else begin
         if (accept && !tok_credit) credit_cnt <= credit_cnt - 1'b1;
         else if (!accept && tok_credit) credit_cnt <= credit_cnt + 1'b1;
         if (accept) hist_vld <= {hist_vld[HIST_LEN-IN_BYTES-1:0], {IN_BYTES{1'b1}}};
         cmp_valid <= accept;
      end
   end

   // hist[0] is the newest byte, i.e. the last byte of the previous word
   always_comb begin
      for (int o = 0; o < TILE_DEPTH; o++) begin
         for (int i = 0; i < IN_BYTES; i++) begin
            eq[o][i] = hist_vld[o + IN_BYTES - 1 - i] &&
                       (hist[o + IN_BYTES - 1 - i] == in_data[i]);
         end
         therm[o][0] = eq[o][0];
         for (int i = 1; i < IN_BYTES; i++) begin
            therm[o][i] = therm[o][i-1] & eq[o][i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         for (int j = IN_BYTES; j < HIST_LEN; j++) hist[j] <= hist[j-IN_BYTES];
         for (int i = 0; i < IN_BYTES; i++) hist[IN_BYTES-1-i] <= in_data[i];
         cmp_therm <= therm;
         cmp_data  <= in_data;
      end
   end

endmodule

`default_nettype wire

//--- logic/lz_longest_tree.sv
// Pairwise selection tree over the per-offset match thermometers.
// Each level keeps the longer of two neighbours and favours the lower
// offset on equal length, then the winner is registered as a length.
`timescale 1ns/1ps
`default_nettype none

module lz_longest_tree import lz_tile_pkg::*; #(
   parameter int TILE_DEPTH = 16
) (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    cmp_valid,
   input  wire len_therm_t [TILE_DEPTH-1:0] cmp_therm,
   input  wire word_t                   cmp_data,
   best_match_if.source                 best
);

   localparam int OW     = $clog2(TILE_DEPTH);
   localparam int LEVELS = $clog2(TILE_DEPTH);

   len_therm_t [LEVELS:0][TILE_DEPTH-1:0]         node_therm;
   logic [LEVELS:0][TILE_DEPTH-1:0][OW-1:0]       node_off;
   logic                                          hi_wins;

   // ==================================================================
   // reduction levels, level 0 holds the raw compare results
   // ==================================================================
   always_comb begin
      node_therm = '0;
      node_off   = '0;
      hi_wins    = 1'b0;
      for (int n = 0; n < TILE_DEPTH; n++) begin
         node_therm[0][n] = cmp_therm[n];
         node_off[0][n]   = OW'(n);
      end
      for (int lvl = 0; lvl < LEVELS; lvl++) begin
         for (int n = 0; n < (TILE_DEPTH >> (lvl + 1)); n++) begin
            // upper side only wins when it reaches a byte the lower one misses
            hi_wins = |(node_therm[lvl][2*n+1] & ~node_therm[lvl][2*n]);
            node_therm[lvl+1][n] = hi_wins ? node_therm[lvl][2*n+1] : node_therm[lvl][2*n];
            node_off[lvl+1][n]   = hi_wins ? node_off[lvl][2*n+1] : node_off[lvl][2*n];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) best.valid <= 1'b0;
      else        best.valid <= cmp_valid;
   end

   always_ff @(posedge clk) begin
      if (cmp_valid) begin
         best.len    <= therm_to_len(node_therm[LEVELS][0]);
         best.offset <= node_off[LEVELS][0];
         best.data   <= cmp_data;
      end
   end

endmodule

`default_nettype wire

//--- logic/lz_match_select.sv
// Token decision stage.
// Weighs the best repeat candidate from the MTF list against the longest
// match from the tree, registers the resulting token and tells the MTF
// list to push a new offset or promote a reused entry.
`timescale 1ns/1ps
`default_nettype none

module lz_match_select import lz_tile_pkg::*; #(
   parameter int TILE_DEPTH = 16,
   parameter int MTF_NUM    = 2
) (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   best_match_if.sink                     best,
   mtf_if.select                          mtf,
   output logic                           tok_valid,
   output tok_kind_e                      tok_kind,
   output logic [$clog2(TILE_DEPTH)-1:0]  tok_offset,
   output len_t                           tok_len,
   output logic [$clog2(MTF_NUM)-1:0]     tok_mtf_idx,
   output word_t                          tok_data
);

   localparam int OW = $clog2(TILE_DEPTH);
   localparam int IW = $clog2(MTF_NUM);

   len_t          rep_len;
   logic [IW-1:0] rep_idx;
   logic [OW-1:0] rep_off;
   logic          use_rep;
   logic          use_match;

   // ==================================================================
   // candidate choice
   // ==================================================================
   always_comb begin
      rep_len = '0;
      rep_idx = '0;
      // strict compare keeps the lower index on equal length
      for (int k = 0; k < MTF_NUM; k++) begin
         if (mtf.ent_len[k] > rep_len) begin
            rep_len = mtf.ent_len[k];
            rep_idx = IW'(k);
         end
      end
   end

   assign rep_off   = mtf.ent_offset[rep_idx];
   assign use_rep   = mtf.valid && (rep_len >= MIN_MATCH) && (rep_len >= best.len);
   assign use_match = !use_rep && (best.len >= MIN_MATCH);

   assign mtf.upd_en     = best.valid && (use_rep || use_match);
   assign mtf.upd_new    = !use_rep;
   assign mtf.upd_offset = use_rep ? rep_off : best.offset;
   assign mtf.upd_idx    = rep_idx;

   // ==================================================================
   // token register
   // ==================================================================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) tok_valid <= 1'b0;
      else        tok_valid <= best.valid;
   end

   always_ff @(posedge clk) begin
      if (best.valid) begin
         tok_data <= best.data;
         if (use_rep) begin
            tok_kind    <= TOK_REP;
            tok_offset  <= rep_off;
            tok_len     <= rep_len;
            tok_mtf_idx <= rep_idx;
         end else if (use_match) begin
            tok_kind    <= TOK_MATCH;
            tok_offset  <= best.offset;
            tok_len     <= best.len;
            tok_mtf_idx <= '0;
         end else begin
            tok_kind    <= TOK_LIT;
            tok_offset  <= '0;
            tok_len     <= '0;
            tok_mtf_idx <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/lz_mtf_lookup.sv
// Move-to-front list of recently used offsets.
// Scores every valid entry against the current compare result, and
// applies push or promote requests coming back from the token selector.
`timescale 1ns/1ps
`default_nettype none

module lz_mtf_lookup import lz_tile_pkg::*; #(
   parameter int TILE_DEPTH = 16,
   parameter int MTF_NUM    = 2
) (
   input  wire logic                        clk,
   input  wire logic                        rst_n,
   input  wire logic                        cmp_valid,
   input  wire len_therm_t [TILE_DEPTH-1:0] cmp_therm,
   mtf_if.lookup                            mtf
);

   localparam int OW = $clog2(TILE_DEPTH);

   // entry 0 is the most recently used offset
   logic [MTF_NUM-1:0][OW-1:0] list_off;
   logic [MTF_NUM-1:0]         list_vld;
   len_t [MTF_NUM-1:0]         sel_len;

   always_comb begin
      for (int k = 0; k < MTF_NUM; k++) begin
         sel_len[k] = list_vld[k] ? therm_to_len(cmp_therm[list_off[k]]) : '0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         list_off  <= '0;
         list_vld  <= '0;
         mtf.valid <= 1'b0;
      end else begin
         mtf.valid <= cmp_valid;
         if (mtf.upd_en && mtf.upd_new) begin
            for (int k = 1; k < MTF_NUM; k++) begin
               list_off[k] <= list_off[k-1];
               list_vld[k] <= list_vld[k-1];
            end
            list_off[0] <= mtf.upd_offset;
            list_vld[0] <= 1'b1;
         end else if (mtf.upd_en) begin
            // entries in front of the promoted one slide back by one place
            for (int k = 1; k < MTF_NUM; k++) begin
               if (k <= mtf.upd_idx) begin
                  list_off[k] <= list_off[k-1];
                  list_vld[k] <= list_vld[k-1];
               end
            end
            list_off[0] <= list_off[mtf.upd_idx];
            list_vld[0] <= list_vld[mtf.upd_idx];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cmp_valid) begin
         mtf.ent_len    <= sel_len;
         mtf.ent_offset <= list_off;
      end
   end

endmodule

`default_nettype wire

//--- logic/lz_tile_ifs.sv
// Internal buses of the match tile.
// best_match_if carries the tree winner to the token selector, mtf_if
// carries MTF lookup results one way and list updates the other way.
`timescale 1ns/1ps
`default_nettype none

interface best_match_if import lz_tile_pkg::*; #(
   parameter int TILE_DEPTH = 16
) ();
   logic                          valid;
   len_t                          len;
   logic [$clog2(TILE_DEPTH)-1:0] offset;
   word_t                         data;

   modport source (output valid, len, offset, data);
   modport sink   (input  valid, len, offset, data);
endinterface

interface mtf_if import lz_tile_pkg::*; #(
   parameter int TILE_DEPTH = 16,
   parameter int MTF_NUM    = 2
) ();
   logic                                        valid;
   len_t [MTF_NUM-1:0]                          ent_len;
   logic [MTF_NUM-1:0][$clog2(TILE_DEPTH)-1:0] ent_offset;
   logic                                        upd_en;
   logic                                        upd_new;
   logic [$clog2(TILE_DEPTH)-1:0]              upd_offset;
   logic [$clog2(MTF_NUM)-1:0]                 upd_idx;

   modport lookup (output valid, ent_len, ent_offset,
                   input  upd_en, upd_new, upd_offset, upd_idx);
   modport select (input  valid, ent_len, ent_offset,
                   output upd_en, upd_new, upd_offset, upd_idx);
endinterface

`default_nettype wire

//--- logic/lz_tile_pkg.sv
// Shared types and constants for the LZ77 match-reduction tile.
// Every RTL block of the tile imports this package by wildcard.
`default_nettype none

package lz_tile_pkg;

   localparam int IN_BYTES  = 4;
   localparam int MIN_MATCH = 2;

   typedef logic [7:0] byte_t;
   // byte 0 is the first byte in stream order
   typedef byte_t [IN_BYTES-1:0] word_t;
   // bit i set when bytes 0 to i all match
   typedef logic [IN_BYTES-1:0] len_therm_t;
   typedef logic [2:0] len_t;

   typedef enum logic [1:0] {
      TOK_LIT   = 2'd0,
      TOK_MATCH = 2'd1,
      TOK_REP   = 2'd2
   } tok_kind_e;

   // leading-ones count of a match thermometer
   function automatic len_t therm_to_len(len_therm_t therm);
      len_t n;
      n = '0;
      for (int i = 0; i < IN_BYTES; i++) begin
         if (therm[i]) n = len_t'(i + 1);
      end
      return n;
   endfunction

endpackage

`default_nettype wire

//--- logic/lz_tile_top.sv
// Top level of the LZ77 match-reduction tile.
// Words enter under credit flow control and leave as one token each,
// three clock edges after acceptance.
`timescale 1ns/1ps
`default_nettype none

module lz_tile_top import lz_tile_pkg::*; #(
   parameter int TILE_DEPTH = 16,
   parameter int MTF_NUM    = 2,
   parameter int CREDITS    = 4
) (
   input  wire logic                      clk,
   input  wire logic                      rst_n,
   input  wire logic                      in_valid,
   input  wire word_t                     in_data,
   input  wire logic                      tok_credit,
   output logic                           in_ready,
   output logic                           tok_valid,
   output tok_kind_e                      tok_kind,
   output logic [$clog2(TILE_DEPTH)-1:0]  tok_offset,
   output len_t                           tok_len,
   output logic [$clog2(MTF_NUM)-1:0]     tok_mtf_idx,
   output word_t                          tok_data
);

   logic                        cmp_valid;
   len_therm_t [TILE_DEPTH-1:0] cmp_therm;
   word_t                       cmp_data;

   best_match_if #(.TILE_DEPTH(TILE_DEPTH)) best_bus ();
   mtf_if #(.TILE_DEPTH(TILE_DEPTH), .MTF_NUM(MTF_NUM)) mtf_bus ();

   lz_history_tile #(.TILE_DEPTH(TILE_DEPTH), .CREDITS(CREDITS)) u_history (
      .clk, .rst_n, .in_valid, .in_data, .tok_credit, .in_ready,
      .cmp_valid, .cmp_therm, .cmp_data
   );

   lz_longest_tree #(.TILE_DEPTH(TILE_DEPTH)) u_tree (
      .clk, .rst_n, .cmp_valid, .cmp_therm, .cmp_data, .best(best_bus.source)
   );

   lz_mtf_lookup #(.TILE_DEPTH(TILE_DEPTH), .MTF_NUM(MTF_NUM)) u_mtf (
      .clk, .rst_n, .cmp_valid, .cmp_therm, .mtf(mtf_bus.lookup)
   );

   lz_match_select #(.TILE_DEPTH(TILE_DEPTH), .MTF_NUM(MTF_NUM)) u_select (
      .clk, .rst_n, .best(best_bus.sink), .mtf(mtf_bus.select),
      .tok_valid, .tok_kind, .tok_offset, .tok_len, .tok_mtf_idx, .tok_data
   );

endmodule

`default_nettype wire

//--- lz_tile.f
logic/lz_tile_pkg.sv
logic/lz_tile_ifs.sv
logic/lz_history_tile.sv
logic/lz_longest_tree.sv
logic/lz_mtf_lookup.sv
logic/lz_match_select.sv
logic/lz_tile_top.sv
dv/lz_tile_props.sv
dv/lz_tile_tb.sv
